//--- logic/turbo_cfg.svh
// fixed widths, depths and opcodes of the turbo command engine, included by every rtl file
`ifndef TURBO_CFG_SVH
`define TURBO_CFG_SVH

// stream beat
`define TURBO_DATA_W          64
`define TURBO_USER_W          32

// line ram, 256 lines of one stream word each
`define TURBO_ADDR_W          8

// words moved per read or write command
`define TURBO_BURST_WORDS     8

// input fifo, 256 words covers a 2000 byte packet
`define TURBO_FIFO_DEPTH_BITS 8

// opcode sits in tdata[63:48] of the header word
`define TURBO_OP_READ         16'h0145
`define TURBO_OP_WRITE        16'h0245

`endif

//--- logic/turbo_pkg.sv
// types shared by the turbo engine, imported into module bodies and scoped in port lists
`default_nettype none
`include "turbo_cfg.svh"

package turbo_pkg;

   // one stream beat, 105 bits
   typedef struct packed {
      logic                         tlast;
      logic [`TURBO_USER_W-1:0]     tuser;
      logic [`TURBO_DATA_W/8-1:0]   tstrb;
      logic [`TURBO_DATA_W-1:0]     tdata;
   } axis_word_t;

   // one line write, parser to ram
   typedef struct packed {
      logic                         en;
      logic [`TURBO_ADDR_W-1:0]     addr;
      logic [`TURBO_DATA_W-1:0]     data;
   } ram_wr_t;

   typedef enum logic [15:0] {
      op_read  = `TURBO_OP_READ,
      op_write = `TURBO_OP_WRITE
   } cmd_opcode_e;

   typedef enum logic [2:0] {
      st_header,  // decode the head word
      st_forward, // pass a plain packet through
      st_write,   // store burst data into the ram
      st_read,    // responder owns the output
      st_drain    // drop the rest of a read request
   } parser_state_e;

endpackage

`default_nettype wire

//--- logic/stream_in_fifo.sv
// show-ahead input fifo for stream beats, written by the slave port and popped by the parser
`timescale 1ns/1ps
`default_nettype none
`include "turbo_cfg.svh"

module stream_in_fifo (
   input  logic                    axi_aclk,
   input  logic                    axi_resetn,
   input  logic                    wr_en,
   input  turbo_pkg::axis_word_t   din,
   input  logic                    pop,
   output turbo_pkg::axis_word_t   head,
   output logic                    empty,
   output logic                    nearly_full
);
   import turbo_pkg::*;

   localparam int depth = 1 << `TURBO_FIFO_DEPTH_BITS;
   // four slots of slack behind tready
   localparam logic [`TURBO_FIFO_DEPTH_BITS:0] nf_level =
      (`TURBO_FIFO_DEPTH_BITS+1)'(depth - 4);

   axis_word_t                        mem [depth];
   logic [`TURBO_FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [`TURBO_FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [`TURBO_FIFO_DEPTH_BITS:0]   count;

   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // idle, or push and pop together
         endcase
      end
   end

   // head is the oldest word, valid whenever not empty
   assign head        = mem[rd_ptr];
   assign empty       = (count == '0);
   assign nearly_full = (count >= nf_level);

   // parser may only pop a word it can see
   a_no_pop_empty: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      pop |-> !empty
   );

   // the slave side stops writing before the buffer runs over
   a_no_overflow: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      wr_en |-> (count < (`TURBO_FIFO_DEPTH_BITS+1)'(depth))
   );

endmodule

`default_nettype wire

//--- logic/line_ram.sv
// 256x64 line memory with one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none
`include "turbo_cfg.svh"

module line_ram (
   input  logic                       axi_aclk,
   input  turbo_pkg::ram_wr_t         wr,
   input  logic [`TURBO_ADDR_W-1:0]   rd_addr,
   output logic [`TURBO_DATA_W-1:0]   rd_data
);

   localparam int lines = 1 << `TURBO_ADDR_W;

   logic [`TURBO_DATA_W-1:0] mem [lines];

   always_ff @(posedge axi_aclk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // one cycle read latency, old data on a same-cycle collision
   always_ff @(posedge axi_aclk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

//--- logic/command_parser.sv
// header decode fsm, steers fifo pops, ram writes, read starts and the output stream select
`timescale 1ns/1ps
`default_nettype none
`include "turbo_cfg.svh"

module command_parser (
   input  logic                       axi_aclk,
   input  logic                       axi_resetn,
   input  turbo_pkg::axis_word_t      head,
   input  logic                       empty,
   output logic                       pop,
   output turbo_pkg::ram_wr_t         wr,
   output logic                       start,
   output logic [`TURBO_ADDR_W-1:0]   start_addr,
   output logic [`TURBO_USER_W-1:0]   start_user,
   input  logic                       done,
   input  turbo_pkg::axis_word_t      resp,
   input  logic                       resp_valid,
   output turbo_pkg::axis_word_t      m_axis,
   output logic                       m_axis_tvalid,
   input  logic                       m_axis_tready
);
   import turbo_pkg::*;

   parser_state_e                        state;
   parser_state_e                        state_next;
   cmd_opcode_e                          opcode;
   logic [`TURBO_ADDR_W-1:0]             wr_addr_q;
   logic [`TURBO_ADDR_W-1:0]             wr_addr_next;
   logic [$clog2(`TURBO_BURST_WORDS):0]  wr_cnt;
   logic [$clog2(`TURBO_BURST_WORDS):0]  wr_cnt_next;
   logic                                 hdr_last;
   logic                                 hdr_last_next;

   assign opcode     = cmd_opcode_e'(head.tdata[`TURBO_DATA_W-1 -: 16]);
   assign start_addr = head.tdata[`TURBO_ADDR_W-1:0];
   assign start_user = head.tuser;

   always_comb begin
      state_next    = state;
      wr_addr_next  = wr_addr_q;
      wr_cnt_next   = wr_cnt;
      hdr_last_next = hdr_last;
      pop           = 1'b0;
      start         = 1'b0;
      wr.en         = 1'b0;
      wr.addr       = wr_addr_q;
      wr.data       = head.tdata;
      m_axis        = head;
      m_axis_tvalid = 1'b0;

      case (state)
         st_header: begin
            if (!empty) begin
               case (opcode)
                  op_write: begin
                     pop          = 1'b1; // header is consumed here
                     wr_addr_next = head.tdata[`TURBO_ADDR_W-1:0];
                     wr_cnt_next  = '0;
                     // single word write packet carries no data
                     state_next   = head.tlast ? st_header : st_write;
                  end
                  op_read: begin
                     pop           = 1'b1;
                     start         = 1'b1;
                     hdr_last_next = head.tlast;
                     state_next    = st_read;
                  end
                  default: begin
                     state_next = st_forward; // header goes out as the first beat
                  end
               endcase
            end
         end

         st_forward: begin
            m_axis_tvalid = !empty;
            pop           = m_axis_tready && !empty;
            if (pop && head.tlast) begin
               state_next = st_header;
            end
         end

         st_write: begin
            if (!empty) begin
               pop = 1'b1;
               // words past the burst are dropped
               if (wr_cnt < `TURBO_BURST_WORDS) begin
                  wr.en        = 1'b1;
                  wr_addr_next = wr_addr_q + 1'b1; // wraps at the top line
                  wr_cnt_next  = wr_cnt + 1'b1;
               end
               if (head.tlast) begin
                  state_next = st_header;
               end
            end
         end

         st_read: begin
            m_axis        = resp;
            m_axis_tvalid = resp_valid;
            if (done) begin
               state_next = hdr_last ? st_header : st_drain;
            end
         end

         st_drain: begin
            if (!empty) begin
               pop = 1'b1;
               if (head.tlast) begin
                  state_next = st_header;
               end
            end
         end

         default: begin
            state_next = st_header;
         end
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state    <= st_header;
         wr_cnt   <= '0;
         hdr_last <= 1'b0;
      end else begin
         state    <= state_next;
         wr_cnt   <= wr_cnt_next;
         hdr_last <= hdr_last_next;
      end
   end

   always_ff @(posedge axi_aclk) begin
      wr_addr_q <= wr_addr_next;
   end

   // a read start never lands in a write burst
   a_start_wr_excl: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      !(start && wr.en)
   );

   a_state_legal: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      state inside {st_header, st_forward, st_write, st_read, st_drain}
   );

endmodule

`default_nettype wire

//--- logic/read_responder.sv
// turns a read start into an eight beat response stream from the line ram, with back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "turbo_cfg.svh"

module read_responder (
   input  logic                       axi_aclk,
   input  logic                       axi_resetn,
   input  logic                       start,
   input  logic [`TURBO_ADDR_W-1:0]   start_addr,
   input  logic [`TURBO_USER_W-1:0]   start_user,
   output logic [`TURBO_ADDR_W-1:0]   rd_addr,
   input  logic [`TURBO_DATA_W-1:0]   rd_data,
   output turbo_pkg::axis_word_t      resp,
   output logic                       resp_valid,
   input  logic                       resp_ready,
   output logic                       done
);

   localparam int cnt_w = $clog2(`TURBO_BURST_WORDS);
   localparam logic [cnt_w-1:0] last_idx = cnt_w'(`TURBO_BURST_WORDS - 1);

   logic                        active;    // burst in progress
   logic                        pend;      // rd_data holds the line at addr_q
   logic [`TURBO_ADDR_W-1:0]    addr_q;
   logic [cnt_w-1:0]            beat_cnt;  // lines moved into resp so far
   logic                        load;
   logic                        last_beat;

   assign load      = pend && (!resp_valid || resp_ready);
   assign last_beat = (beat_cnt == last_idx);

   // step on when the line is taken, otherwise re-read the same line
   assign rd_addr = start ? start_addr : (load ? addr_q + 1'b1 : addr_q);

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         active     <= 1'b0;
         pend       <= 1'b0;
         beat_cnt   <= '0;
         resp_valid <= 1'b0;
         done       <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start) begin
            active   <= 1'b1;
            pend     <= 1'b1;
            beat_cnt <= '0;
         end else if (load) begin
            pend     <= !last_beat;
            beat_cnt <= beat_cnt + 1'b1;
         end
         if (load) begin
            resp_valid <= 1'b1;
         end else if (resp_ready) begin
            resp_valid <= 1'b0;
         end
         if (resp_valid && resp_ready && resp.tlast) begin
            active <= 1'b0;
            done   <= 1'b1;
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (start) begin
         addr_q     <= start_addr;
         resp.tuser <= start_user; // same tuser on every beat
      end else if (load) begin
         addr_q <= addr_q + 1'b1;
      end
      if (load) begin
         resp.tdata <= rd_data;
         resp.tstrb <= '1;
         resp.tlast <= last_beat;
      end
   end

   a_valid_in_burst: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      resp_valid |-> active
   );

   // parser waits for done before the next read
   a_no_restart: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      start |-> !active
   );

endmodule

`default_nettype wire

//--- logic/ualink_turbo_top.sv
// top level of the turbo command engine, one axi-stream slave in and one master out
`timescale 1ns/1ps
`default_nettype none
`include "turbo_cfg.svh"

module ualink_turbo_top (
   input  logic                         axi_aclk,
   input  logic                         axi_resetn,
   input  logic [`TURBO_DATA_W-1:0]     s_axis_tdata,
   input  logic [`TURBO_DATA_W/8-1:0]   s_axis_tstrb,
   input  logic [`TURBO_USER_W-1:0]     s_axis_tuser,
   input  logic                         s_axis_tlast,
   input  logic                         s_axis_tvalid,
   output logic                         s_axis_tready,
   output logic [`TURBO_DATA_W-1:0]     m_axis_tdata,
   output logic [`TURBO_DATA_W/8-1:0]   m_axis_tstrb,
   output logic [`TURBO_USER_W-1:0]     m_axis_tuser,
   output logic                         m_axis_tlast,
   output logic                         m_axis_tvalid,
   input  logic                         m_axis_tready
);
   import turbo_pkg::*;

   axis_word_t                 in_word;
   axis_word_t                 head;
   axis_word_t                 resp;
   axis_word_t                 out_word;
   ram_wr_t                    wr;
   logic                       fifo_wr;
   logic                       empty;
   logic                       nearly_full;
   logic                       pop;
   logic                       start;
   logic                       done;
   logic                       resp_valid;
   logic [`TURBO_ADDR_W-1:0]   start_addr;
   logic [`TURBO_ADDR_W-1:0]   rd_addr;
   logic [`TURBO_USER_W-1:0]   start_user;
   logic [`TURBO_DATA_W-1:0]   rd_data;

   assign in_word       = '{tlast: s_axis_tlast, tuser: s_axis_tuser,
                            tstrb: s_axis_tstrb, tdata: s_axis_tdata};
   assign fifo_wr       = s_axis_tvalid && !nearly_full;
   assign s_axis_tready = !nearly_full;

   assign m_axis_tdata  = out_word.tdata;
   assign m_axis_tstrb  = out_word.tstrb;
   assign m_axis_tuser  = out_word.tuser;
   assign m_axis_tlast  = out_word.tlast;

   stream_in_fifo fifo0 (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .wr_en(fifo_wr), .din(in_word), .pop(pop),
      .head(head), .empty(empty), .nearly_full(nearly_full)
   );

   command_parser parser0 (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .head(head), .empty(empty), .pop(pop), .wr(wr),
      .start(start), .start_addr(start_addr), .start_user(start_user),
      .done(done), .resp(resp), .resp_valid(resp_valid),
      .m_axis(out_word), .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready)
   );

   line_ram ram0 (
      .axi_aclk(axi_aclk), .wr(wr), .rd_addr(rd_addr), .rd_data(rd_data)
   );

   // responder only holds valid while the parser routes it out
   read_responder resp0 (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .start(start), .start_addr(start_addr), .start_user(start_user),
      .rd_addr(rd_addr), .rd_data(rd_data),
      .resp(resp), .resp_valid(resp_valid), .resp_ready(m_axis_tready), .done(done)
   );

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
// scoreboard for the turbo engine, models the line ram from the slave stream and checks m_axis
`timescale 1ns/1ps
`default_nettype none
`include "turbo_cfg.svh"

module tb_checker (
   input  logic                         axi_aclk,
   input  logic                         axi_resetn,
   input  logic [`TURBO_DATA_W-1:0]     s_axis_tdata,
   input  logic [`TURBO_DATA_W/8-1:0]   s_axis_tstrb,
   input  logic [`TURBO_USER_W-1:0]     s_axis_tuser,
   input  logic                         s_axis_tlast,
   input  logic                         s_axis_tvalid,
   input  logic                         s_axis_tready,
   input  logic [`TURBO_DATA_W-1:0]     m_axis_tdata,
   input  logic [`TURBO_DATA_W/8-1:0]   m_axis_tstrb,
   input  logic [`TURBO_USER_W-1:0]     m_axis_tuser,
   input  logic                         m_axis_tlast,
   input  logic                         m_axis_tvalid,
   input  logic                         m_axis_tready,
   output int                           tests_done,
   output int                           errors,
   output int                           pending
);
   import turbo_pkg::*;

   axis_word_t                 exp_q [$];
   int                         tag_q [$];   // test index of each expected beat
   logic [`TURBO_DATA_W-1:0]   model [1 << `TURBO_ADDR_W];
   string                      names [32];
   int                         want_beats [32];
   int                         pushed [32];
   int                         seen [32];
   int                         bad [32];
   logic [15:0]                opcode;      // packet in flight on the slave side
   logic [`TURBO_ADDR_W-1:0]   wr_addr;
   int                         pkt = 0;
   int                         in_cnt = 0;
   int                         rst_cnt = 0;

   initial begin
      tests_done = 0;
      errors     = 0;
      pending    = 0;
   end

   task expect_test(input int idx, input string name, input int beats);
      names[idx]      = name;
      want_beats[idx] = beats;
      pushed[idx]     = 0;
      seen[idx]       = 0;
      bad[idx]        = 0;
   endtask

   task push_beat(input axis_word_t b);
      exp_q.push_back(b);
      tag_q.push_back(pkt);
      pushed[pkt]++;
   endtask

   task check_field(input int tag, input string sig, input logic [63:0] want_v,
                    input logic [63:0] got_v);
      if (got_v !== want_v) begin
         $display("[ERROR] %0t %s expected %h actual %h", $time, sig, want_v, got_v);
         errors++;
         if (tag >= 0) begin
            bad[tag]++;
         end
      end
   endtask

   // a test is over once its packet is in and all its beats came out
   task close_test(input int tag);
      if (tag < pkt && seen[tag] == pushed[tag]) begin
         $display("test %0d %s done: %0d beats, %0d mismatches",
                  tag, names[tag], seen[tag], bad[tag]);
         tests_done++;
      end
   endtask

   always @(posedge axi_aclk) begin
      axis_word_t               w;
      axis_word_t               e;
      logic [`TURBO_ADDR_W-1:0] ra;
      int                       tag;
      // reset cycles and the first two after release
      if (rst_cnt >= 1 && rst_cnt <= 11) begin
         check_field(-1, "m_axis_tvalid", '0, m_axis_tvalid);
         check_field(-1, "s_axis_tready", 64'd1, s_axis_tready);
      end
      rst_cnt++;

      if (axi_resetn && s_axis_tvalid && s_axis_tready) begin
         w = {s_axis_tlast, s_axis_tuser, s_axis_tstrb, s_axis_tdata};
         if (in_cnt == 0) begin
            opcode = w.tdata[`TURBO_DATA_W-1 -: 16];
         end
         if (opcode == `TURBO_OP_WRITE) begin
            if (in_cnt == 0) begin
               wr_addr = w.tdata[`TURBO_ADDR_W-1:0];
            end else if (in_cnt <= `TURBO_BURST_WORDS) begin
               ra        = wr_addr + in_cnt - 1; // wraps at line 255
               model[ra] = w.tdata;
            end
         end else if (opcode == `TURBO_OP_READ) begin
            if (in_cnt == 0) begin
               for (int k = 0; k < `TURBO_BURST_WORDS; k++) begin
                  ra      = w.tdata[`TURBO_ADDR_W-1:0] + k;
                  e.tlast = (k == `TURBO_BURST_WORDS - 1);
                  e.tuser = w.tuser;
                  e.tstrb = '1;
                  e.tdata = model[ra];
                  push_beat(e);
               end
            end
         end else begin
            push_beat(w); // plain packet passes unchanged
         end
         in_cnt++;
         if (w.tlast) begin
            if (pushed[pkt] != want_beats[pkt]) begin
               $display("test %0d %s: the packet gives %0d output beats but the table says %0d",
                        pkt, names[pkt], pushed[pkt], want_beats[pkt]);
               errors++;
            end
            in_cnt = 0;
            pkt++;
            close_test(pkt - 1);
         end
      end

      if (axi_resetn && m_axis_tvalid && m_axis_tready) begin
         if (exp_q.size() == 0) begin
            $display("unexpected output beat at %0t with tdata %h, no beat was expected",
                     $time, m_axis_tdata);
            errors++;
         end else begin
            e   = exp_q.pop_front();
            tag = tag_q.pop_front();
            check_field(tag, "m_axis_tdata", e.tdata, m_axis_tdata);
            check_field(tag, "m_axis_tstrb", e.tstrb, m_axis_tstrb);
            check_field(tag, "m_axis_tuser", e.tuser, m_axis_tuser);
            check_field(tag, "m_axis_tlast", e.tlast, m_axis_tlast);
            seen[tag]++;
            close_test(tag);
         end
      end
      pending = exp_q.size();
   end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
// testbench top that drives the stimulus table through dut0 and ends the run
`timescale 1ns/1ps
`default_nettype none
`include "turbo_cfg.svh"

module tb_top;

   localparam int         num_tests = 13;
   localparam logic [1:0] kind_fwd  = 2'd0;
   localparam logic [1:0] kind_wr   = 2'd1;
   localparam logic [1:0] kind_rd   = 2'd2;

   typedef struct packed {
      logic [1:0]  kind;
      logic [7:0]  addr;
      logic [7:0]  count;  // data words after a header or all words of a plain packet
      logic [31:0] user;
      logic [63:0] seed;
      logic        bp;     // random tready once this row starts
      logic [7:0]  beats;  // expected output beats
   } test_row_t;

   test_row_t                    rows [num_tests];
   string                        names [num_tests];
   logic                         axi_aclk;
   logic                         axi_resetn;
   logic [`TURBO_DATA_W-1:0]     s_axis_tdata;
   logic [`TURBO_DATA_W/8-1:0]   s_axis_tstrb;
   logic [`TURBO_USER_W-1:0]     s_axis_tuser;
   logic                         s_axis_tlast;
   logic                         s_axis_tvalid;
   logic                         s_axis_tready;
   logic [`TURBO_DATA_W-1:0]     m_axis_tdata;
   logic [`TURBO_DATA_W/8-1:0]   m_axis_tstrb;
   logic [`TURBO_USER_W-1:0]     m_axis_tuser;
   logic                         m_axis_tlast;
   logic                         m_axis_tvalid;
   logic                         m_axis_tready;
   logic                         bp_on;
   logic [31:0]                  rng_state;
   int                           limit = 0;
   int                           cycles;
   int                           tests_done;
   int                           errors;
   int                           pending;

   ualink_turbo_top dut0 (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .s_axis_tdata(s_axis_tdata), .s_axis_tstrb(s_axis_tstrb), .s_axis_tuser(s_axis_tuser),
      .s_axis_tlast(s_axis_tlast), .s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
      .m_axis_tdata(m_axis_tdata), .m_axis_tstrb(m_axis_tstrb), .m_axis_tuser(m_axis_tuser),
      .m_axis_tlast(m_axis_tlast), .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready)
   );

   tb_checker chk0 (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .s_axis_tdata(s_axis_tdata), .s_axis_tstrb(s_axis_tstrb), .s_axis_tuser(s_axis_tuser),
      .s_axis_tlast(s_axis_tlast), .s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
      .m_axis_tdata(m_axis_tdata), .m_axis_tstrb(m_axis_tstrb), .m_axis_tuser(m_axis_tuser),
      .m_axis_tlast(m_axis_tlast), .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
      .tests_done(tests_done), .errors(errors), .pending(pending)
   );

   initial begin
      axi_aclk = 1'b0;
      forever #50 axi_aclk = ~axi_aclk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // tready low on roughly one cycle in three for flagged rows
   always @(negedge axi_aclk) begin
      if (bp_on) begin
         rng_state     = xorshift32(rng_state);
         m_axis_tready = (rng_state % 3) != 0;
      end else begin
         m_axis_tready = 1'b1;
      end
   end

   task set_row(input int idx, input string name, input logic [1:0] kind, input logic [7:0] addr,
                input logic [7:0] count, input logic [31:0] user, input logic [63:0] seed,
                input logic bp, input logic [7:0] beats);
      names[idx] = name;
      rows[idx]  = '{kind, addr, count, user, seed, bp, beats};
   endtask

   // starts on a falling edge and returns on the one after the beat was taken
   task send_beat(input logic [63:0] data, input logic [7:0] strb, input logic [31:0] user,
                  input logic last);
      s_axis_tdata  = data;
      s_axis_tstrb  = strb;
      s_axis_tuser  = user;
      s_axis_tlast  = last;
      s_axis_tvalid = 1'b1;
      while (s_axis_tready !== 1'b1) @(negedge axi_aclk);
      @(negedge axi_aclk);
      s_axis_tvalid = 1'b0;
   endtask

   task send_packet(input test_row_t r);
      int n;
      n = r.count;
      case (r.kind)
         kind_fwd: begin
            for (int i = 0; i < n; i++) begin
               send_beat(r.seed + i, 8'hA5 ^ 8'(i), r.user + i, i == n - 1);
            end
         end
         kind_wr: begin
            send_beat({`TURBO_OP_WRITE, 40'h0, r.addr}, 8'hFF, r.user, n == 0);
            for (int i = 0; i < n; i++) begin
               send_beat(r.seed + i, 8'hFF, r.user, i == n - 1);
            end
         end
         default: begin
            send_beat({`TURBO_OP_READ, 40'h0, r.addr}, 8'hFF, r.user, 1'b1); // header only
         end
      endcase
   endtask

   initial begin
      int words;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = 1'b1;
      bp_on         = 1'b0;
      rng_state     = 32'd19764;
      //      idx name          kind      addr   cnt  user          seed                   bp beats
      set_row(0, "fwd_basic",   kind_fwd, 8'h00, 5,  32'h0000_0011, 64'h1111_0000_0000_0100, 0, 5);
      set_row(1, "wr_10",       kind_wr,  8'h10, 8,  32'h0000_0021, 64'hA000_0000_0000_0010, 0, 0);
      set_row(2, "rd_10",       kind_rd,  8'h10, 0,  32'hBEEF_0002, 64'h0,                   0, 8);
      set_row(3, "wr_wrap",     kind_wr,  8'hFC, 8,  32'h0000_0031, 64'hB000_0000_0000_00FC, 0, 0);
      set_row(4, "rd_wrap",     kind_rd,  8'hFC, 0,  32'hBEEF_0004, 64'h0,                   0, 8);
      set_row(5, "wr_48",       kind_wr,  8'h48, 8,  32'h0000_0051, 64'hC000_0000_0000_0048, 0, 0);
      set_row(6, "wr_long_40",  kind_wr,  8'h40, 10, 32'h0000_0061, 64'hD000_0000_0000_0040, 0, 0);
      set_row(7, "rd_44",       kind_rd,  8'h44, 0,  32'hBEEF_0007, 64'h0,                   0, 8);
      set_row(8, "bp_fwd_a",    kind_fwd, 8'h00, 7,  32'h0000_0081, 64'h2222_0000_0000_0000, 1, 7);
      set_row(9, "bp_rd_10",    kind_rd,  8'h10, 0,  32'hBEEF_0009, 64'h0,                   1, 8);
      set_row(10, "bp_fwd_b",   kind_fwd, 8'h00, 3,  32'h0000_00A1, 64'h3333_0000_0000_0000, 1, 3);
      set_row(11, "bp_rd_wrap", kind_rd,  8'hFC, 0,  32'hBEEF_000B, 64'h0,                   1, 8);
      set_row(12, "bp_fwd_one", kind_fwd, 8'h00, 1,  32'h0000_00C1, 64'h4444_0000_0000_0000, 1, 1);
      words = 0;
      foreach (rows[i]) words += rows[i].count + rows[i].beats + 1;
      limit = words * 4 + 200;

      repeat (10) @(negedge axi_aclk);
      axi_resetn = 1'b1;
      @(negedge axi_aclk);
      for (int i = 0; i < num_tests; i++) begin
         chk0.expect_test(i, names[i], rows[i].beats);
         bp_on = rows[i].bp;
         send_packet(rows[i]);
      end
      // responses lag the slave side, so tready stays random until they are out
      while (tests_done < num_tests) @(posedge axi_aclk);
      bp_on = 1'b0;
      repeat (20) @(negedge axi_aclk); // stray beats would show up in this quiet time
      $display("%0d of %0d tests done, %0d errors, %0d beats still expected",
               tests_done, num_tests, errors, pending);
      if (errors == 0 && pending == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      cycles = 0;
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge axi_aclk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d clock cycles", limit);
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/turbo_pkg.sv
logic/stream_in_fifo.sv
logic/line_ram.sv
logic/command_parser.sv
logic/read_responder.sv
logic/ualink_turbo_top.sv
verif/tb_checker.sv
verif/tb_top.sv
